// File: vlog.f
+incdir+hdl
+incdir+sim
hdl/gpio_pkg.sv
hdl/gpio_reg_bus.sv
hdl/gpio_port_regs.sv
hdl/gpio_edge_irq.sv
hdl/gpio_top.sv
sim/gpio_tb.sv

// File: sim/gpio_tb_tasks.svh
// AXI4-Lite master tasks for the GPIO testbench, included inside the testbench module
// inputs change on the falling edge, responses are sampled 1 ns after it
`ifndef GPIO_TB_TASKS_SVH
`define GPIO_TB_TASKS_SVH

// random hold-off on bready / rready, 0 to 4 cycles
task automatic stall_ready();
    repeat ($urandom_range(4, 0)) @(negedge clk);
endtask

// same write issued twice, the repeat waits behind the first response
task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [1:0] exp_resp);
    @(negedge clk);
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_awvalid_i = 1'b1;         // aw and w offered together
    s_wvalid_i  = 1'b1;
    for (int n = 0; n < 2; n++)
    begin
        #1;
        while (!s_awready_o)
        begin
            @(negedge clk);
            #1;
        end
        check_eq("s_wready_o", s_wready_o, 1'b1);
        @(negedge clk);         // taken on the rising edge just passed
        if (n == 1)
        begin
            s_awvalid_i = 1'b0;
            s_wvalid_i  = 1'b0;
        end
        stall_ready();          // bvalid must hold meanwhile
        s_bready_i = 1'b1;
        #1;
        check_eq("s_bvalid_o", s_bvalid_o, 1'b1);
        check_eq("s_bresp_o", s_bresp_o, exp_resp);
        @(negedge clk);
        s_bready_i = 1'b0;
    end
endtask

// same read issued twice, arvalid stays up through the first response
task automatic axi_read(input logic [7:0] addr, input logic [31:0] exp_data,
                        input logic [1:0] exp_resp);
    @(negedge clk);
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    for (int n = 0; n < 2; n++)
    begin
        #1;
        while (!s_arready_o)
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        if (n == 1)
            s_arvalid_i = 1'b0;
        stall_ready();          // rvalid and rdata must hold meanwhile
        s_rready_i = 1'b1;
        #1;
        check_eq("s_rvalid_o", s_rvalid_o, 1'b1);
        check_eq("s_rresp_o", s_rresp_o, exp_resp);
        check_eq("s_rdata_o", s_rdata_o, exp_data);
        @(negedge clk);
        s_rready_i = 1'b0;
    end
endtask

`endif

// File: sim/gpio_tb.sv
// testbench for the GPIO peripheral, AXI4-Lite register traffic plus pad stimulus
// keeps its own register model, assertions do the checking
`timescale 1ns/1ns
`include "gpio_macros.svh"

module gpio_tb;

    localparam int          period   = 10;
    localparam int          pin_w    = `GPIO_WIDTH;
    localparam int          n_io     = 8;      // GPO/DIR rounds
    localparam int          n_in     = 6;      // input rounds
    localparam int          n_edge   = 8;      // edge rounds
    // upper bound, every task call issues its transfer twice
    localparam int          n_trans  = 2 * (6 + 4*n_io + n_in + 2*n_edge + 24);
    localparam int          n_pads   = n_in + n_edge + 1;                   // 6 cycles each

    logic                       clk;
    logic                       resetn;
    logic [`GPIO_AXI_AW-1:0]    s_awaddr_i;
    logic                       s_awvalid_i;
    logic                       s_awready_o;
    logic [`GPIO_AXI_DW-1:0]    s_wdata_i;
    logic [`GPIO_AXI_DW/8-1:0]  s_wstrb_i;
    logic                       s_wvalid_i;
    logic                       s_wready_o;
    logic [1:0]                 s_bresp_o;
    logic                       s_bvalid_o;
    logic                       s_bready_i;
    logic [`GPIO_AXI_AW-1:0]    s_araddr_i;
    logic                       s_arvalid_i;
    logic                       s_arready_o;
    logic [`GPIO_AXI_DW-1:0]    s_rdata_o;
    logic [1:0]                 s_rresp_o;
    logic                       s_rvalid_o;
    logic                       s_rready_i;
    logic [pin_w-1:0]           pad_in_i;
    logic [pin_w-1:0]           pad_out_o;
    logic [pin_w-1:0]           pad_dir_o;
    logic                       irq_o;

    // register model
    logic [pin_w-1:0]   gpo_m;
    logic [pin_w-1:0]   dir_m;
    logic [pin_w-1:0]   pol_m;
    logic [pin_w-1:0]   ien_m;
    logic [pin_w-1:0]   ist_m;

    gpio_top i_dut (.*);

    always #(period/2) clk = ~clk;

    // stop at the first failed check
    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    `include "gpio_tb_tasks.svh"

    // expected read data per offset, zero for holes
    function automatic logic [31:0] model_read(input logic [7:0] addr);
        case (addr)
            `GPIO_OFS_GPI : return 32'(pad_in_i);   // pads held long enough to sync
            `GPIO_OFS_GPO : return 32'(gpo_m);
            `GPIO_OFS_DIR : return 32'(dir_m);
            `GPIO_OFS_POL : return 32'(pol_m);
            `GPIO_OFS_IEN : return 32'(ien_m);
            `GPIO_OFS_IST : return 32'(ist_m);
            default       : return '0;
        endcase
    endfunction

    task automatic reg_check(input logic [7:0] addr);
        axi_read(addr, model_read(addr), `GPIO_RESP_OKAY);
    endtask

    // good write, then pads and irq must match the model at bvalid
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        axi_write(addr, data, 4'hf, `GPIO_RESP_OKAY);
        case (addr)
            `GPIO_OFS_GPO : gpo_m = data[pin_w-1:0];
            `GPIO_OFS_DIR : dir_m = data[pin_w-1:0];
            `GPIO_OFS_POL : pol_m = data[pin_w-1:0];
            `GPIO_OFS_IEN : ien_m = data[pin_w-1:0];
            `GPIO_OFS_IST : ist_m = ist_m & ~data[pin_w-1:0];  // w1c
            default       : ;                                  // GPI is read only
        endcase
        check_eq("pad_out_o", pad_out_o, gpo_m);
        check_eq("pad_dir_o", pad_dir_o, dir_m);
        check_eq("irq_o", irq_o, |(ist_m & ien_m));
    endtask

    // new pad pattern, record the edges it makes and let status settle
    task automatic drive_pads(input logic [pin_w-1:0] value);
        logic [pin_w-1:0] prev;
        prev = pad_in_i;
        @(negedge clk);
        pad_in_i = value;
        ist_m = ist_m | (value & ~prev & pol_m) | (~value & prev & ~pol_m);
        repeat (5) @(negedge clk);     // 2 sync, 1 detect, 1 status, 1 spare
        check_eq("irq_o", irq_o, |(ist_m & ien_m));
    endtask

    a_reset_out : assert property (@(posedge clk)
        !resetn |-> (pad_out_o == '0 && pad_dir_o == '0 && !irq_o && !s_bvalid_o && !s_rvalid_o))
        else
        begin
            $display("MISMATCH reset outputs pad_out_o %h pad_dir_o %h irq_o %h", pad_out_o,
                     pad_dir_o, irq_o);
            abort_run();
        end

    a_b_hold : assert property (@(posedge clk) disable iff (!resetn)
        (s_bvalid_o && !s_bready_i) |=> (s_bvalid_o && $stable(s_bresp_o)))
        else
        begin
            $display("MISMATCH s_bvalid_o %h s_bresp_o %h under back-pressure", s_bvalid_o,
                     s_bresp_o);
            abort_run();
        end

    a_r_hold : assert property (@(posedge clk) disable iff (!resetn)
        (s_rvalid_o && !s_rready_i) |=> (s_rvalid_o && $stable(s_rresp_o) && $stable(s_rdata_o)))
        else
        begin
            $display("MISMATCH s_rvalid_o %h s_rresp_o %h s_rdata_o %h under back-pressure",
                     s_rvalid_o, s_rresp_o, s_rdata_o);
            abort_run();
        end

    // one transaction at a time, one response channel at a time
    a_one_txn : assert property (@(posedge clk) disable iff (!resetn)
        (s_bvalid_o || s_rvalid_o) |-> !(s_awready_o || s_arready_o || (s_bvalid_o && s_rvalid_o)))
        else
        begin
            $display("MISMATCH s_awready_o %h s_arready_o %h s_bvalid_o %h s_rvalid_o %h",
                     s_awready_o, s_arready_o, s_bvalid_o, s_rvalid_o);
            abort_run();
        end

    // watchdog, 200 cycles per transaction plus pad settling and reset
    initial
    begin
        #((n_trans * 200 + n_pads * 6 + 100) * period);
        $display("timeout, the test sequence never finished");
        abort_run();
    end

    initial
    begin
        void'($urandom(32'hce98));
        clk         = 1'b0;
        resetn      = 1'b0;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        pad_in_i    = pin_w'($urandom());
        gpo_m = '0;
        dir_m = '0;
        pol_m = '0;
        ien_m = '0;
        ist_m = '0;     // rising edges out of reset, POL 0 ignores them
        repeat (16) @(negedge clk);
        resetn = 1'b1;
        repeat (3) @(negedge clk);

        // reset values, offsets 0x00 to 0x14
        check_eq("pad_out_o", pad_out_o, '0);
        check_eq("pad_dir_o", pad_dir_o, '0);
        check_eq("irq_o", irq_o, 1'b0);
        for (int i = 0; i < 6; i++)
            reg_check(8'(4 * i));

        for (int i = 0; i < n_io; i++)
        begin
            reg_write(`GPIO_OFS_GPO, $urandom());
            reg_write(`GPIO_OFS_DIR, $urandom());
            reg_check(`GPIO_OFS_GPO);
            reg_check(`GPIO_OFS_DIR);
        end

        // input path, falling edges pile up in IST with irq masked
        for (int i = 0; i < n_in; i++)
        begin
            drive_pads(pin_w'($urandom()));
            reg_check(`GPIO_OFS_GPI);
        end
        reg_check(`GPIO_OFS_IST);

        reg_write(`GPIO_OFS_IST, 32'hffff_ffff);
        reg_write(`GPIO_OFS_POL, $urandom());
        reg_write(`GPIO_OFS_IEN, $urandom());
        for (int i = 0; i < n_edge; i++)
        begin
            drive_pads(pin_w'($urandom()));
            reg_check(`GPIO_OFS_IST);
            reg_write(`GPIO_OFS_IST, $urandom());   // clear a random subset
        end

        // every pin toggles with irq disabled
        reg_write(`GPIO_OFS_IEN, 32'h0);
        drive_pads(~pad_in_i);
        reg_check(`GPIO_OFS_IST);

        // error responses change nothing
        axi_write(8'h18, $urandom(), 4'hf, `GPIO_RESP_SLVERR);
        axi_write(8'h05, $urandom(), 4'hf, `GPIO_RESP_SLVERR);      // unaligned
        axi_write(`GPIO_OFS_GPO, ~32'(gpo_m), 4'b0011, `GPIO_RESP_SLVERR);
        axi_write(`GPIO_OFS_POL, ~32'(pol_m), 4'b1110, `GPIO_RESP_SLVERR);
        axi_read(8'h1C, 32'h0, `GPIO_RESP_SLVERR);
        axi_write(`GPIO_OFS_GPI, $urandom(), 4'hf, `GPIO_RESP_OKAY);  // dropped
        for (int i = 0; i < 6; i++)
            reg_check(8'(4 * i));
        check_eq("pad_out_o", pad_out_o, gpo_m);
        check_eq("pad_dir_o", pad_dir_o, dir_m);

        repeat (2) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule : gpio_tb

// File: hdl/gpio_top.sv
// GPIO peripheral top, AXI4-Lite slave plus pad and interrupt pins
// instantiate once per GPIO bank in the SoC
`timescale 1ns/1ns
`include "gpio_macros.svh"

module gpio_top
(
    input   logic                           clk,
    input   logic                           resetn,
    // AXI4-Lite slave
    input   logic [`GPIO_AXI_AW-1:0]        s_awaddr_i,
    input   logic                           s_awvalid_i,
    output  logic                           s_awready_o,
    input   logic [`GPIO_AXI_DW-1:0]        s_wdata_i,
    input   logic [`GPIO_AXI_DW/8-1:0]      s_wstrb_i,
    input   logic                           s_wvalid_i,
    output  logic                           s_wready_o,
    output  logic [1:0]                     s_bresp_o,
    output  logic                           s_bvalid_o,
    input   logic                           s_bready_i,
    input   logic [`GPIO_AXI_AW-1:0]        s_araddr_i,
    input   logic                           s_arvalid_i,
    output  logic                           s_arready_o,
    output  logic [`GPIO_AXI_DW-1:0]        s_rdata_o,
    output  logic [1:0]                     s_rresp_o,
    output  logic                           s_rvalid_o,
    input   logic                           s_rready_i,
    // pads
    input   logic [`GPIO_WIDTH-1:0]         pad_in_i,
    output  logic [`GPIO_WIDTH-1:0]         pad_out_o,
    output  logic [`GPIO_WIDTH-1:0]         pad_dir_o,
    output  logic                           irq_o
);
    import gpio_pkg::*;

    logic                       wr_en;
    gpio_reg_e                  wr_sel;
    logic [`GPIO_AXI_DW-1:0]    wr_data;
    gpio_reg_e                  rd_sel;
    logic [`GPIO_AXI_DW-1:0]    port_rd_data;
    logic [`GPIO_AXI_DW-1:0]    irq_rd_data;
    logic [`GPIO_WIDTH-1:0]     pin_sync;   // port block to edge block

    gpio_reg_bus i_reg_bus
    (
        .clk            (clk),
        .resetn         (resetn),
        .s_awaddr_i     (s_awaddr_i),
        .s_awvalid_i    (s_awvalid_i),
        .s_awready_o    (s_awready_o),
        .s_wdata_i      (s_wdata_i),
        .s_wstrb_i      (s_wstrb_i),
        .s_wvalid_i     (s_wvalid_i),
        .s_wready_o     (s_wready_o),
        .s_bresp_o      (s_bresp_o),
        .s_bvalid_o     (s_bvalid_o),
        .s_bready_i     (s_bready_i),
        .s_araddr_i     (s_araddr_i),
        .s_arvalid_i    (s_arvalid_i),
        .s_arready_o    (s_arready_o),
        .s_rdata_o      (s_rdata_o),
        .s_rresp_o      (s_rresp_o),
        .s_rvalid_o     (s_rvalid_o),
        .s_rready_i     (s_rready_i),
        .wr_en_o        (wr_en),
        .wr_sel_o       (wr_sel),
        .wr_data_o      (wr_data),
        .rd_sel_o       (rd_sel),
        .port_rd_data_i (port_rd_data),
        .irq_rd_data_i  (irq_rd_data)
    );

    gpio_port_regs #(.gpio_w(`GPIO_WIDTH)) i_port_regs
    (
        .clk            (clk),
        .resetn         (resetn),
        .wr_en_i        (wr_en),
        .wr_sel_i       (wr_sel),
        .wr_data_i      (wr_data),
        .rd_sel_i       (rd_sel),
        .pad_in_i       (pad_in_i),
        .pad_out_o      (pad_out_o),
        .pad_dir_o      (pad_dir_o),
        .pin_sync_o     (pin_sync),
        .port_rd_data_o (port_rd_data)
    );

    gpio_edge_irq #(.gpio_w(`GPIO_WIDTH)) i_edge_irq
    (
        .clk            (clk),
        .resetn         (resetn),
        .wr_en_i        (wr_en),
        .wr_sel_i       (wr_sel),
        .wr_data_i      (wr_data),
        .rd_sel_i       (rd_sel),
        .pin_sync_i     (pin_sync),
        .irq_rd_data_o  (irq_rd_data),
        .irq_o          (irq_o)
    );

endmodule : gpio_top

// File: hdl/gpio_edge_irq.sv
// per-pin edge detection with polarity, enable and sticky status
// irq_o is the OR of status AND enable
`timescale 1ns/1ns
`include "gpio_macros.svh"

module gpio_edge_irq
#(
    parameter int gpio_w = `GPIO_WIDTH
)(
    input   logic                           clk,
    input   logic                           resetn,
    // register port from the front end
    input   logic                           wr_en_i,
    input   gpio_pkg::gpio_reg_e            wr_sel_i,
    input   logic [`GPIO_AXI_DW-1:0]        wr_data_i,
    input   gpio_pkg::gpio_reg_e            rd_sel_i,
    // synchronized pins from the port block
    input   logic [gpio_w-1:0]              pin_sync_i,
    output  logic [`GPIO_AXI_DW-1:0]        irq_rd_data_o,
    output  logic                           irq_o
);
    import gpio_pkg::*;

    localparam int dw = `GPIO_AXI_DW;

    logic [gpio_w-1:0]  pol_r;      // 1 = rising, 0 = falling
    logic [gpio_w-1:0]  ien_r;
    logic [gpio_w-1:0]  ist_r;      // sticky
    logic [gpio_w-1:0]  prev_r;     // pins one cycle back
    logic [gpio_w-1:0]  edge_r;     // registered edge hits
    logic [gpio_w-1:0]  hit;
    logic [gpio_w-1:0]  clr;        // w1c mask

    // edge of the selected polarity
    assign hit = ( pin_sync_i & ~prev_r &  pol_r)
               | (~pin_sync_i &  prev_r & ~pol_r);

    assign clr = (wr_en_i && wr_sel_i == REG_IST) ? wr_data_i[gpio_w-1:0] : '0;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            pol_r  <= '0;
            ien_r  <= '0;
            ist_r  <= '0;
            prev_r <= '0;
            edge_r <= '0;
        end
        else
        begin
            prev_r <= pin_sync_i;
            edge_r <= hit;
            ist_r  <= (ist_r & ~clr) | edge_r;     // new edge wins over clear
            if (wr_en_i && wr_sel_i == REG_POL)
                pol_r <= wr_data_i[gpio_w-1:0];
            if (wr_en_i && wr_sel_i == REG_IEN)
                ien_r <= wr_data_i[gpio_w-1:0];
        end
    end

    assign irq_o = |(ist_r & ien_r);

    always_comb
    begin
        case (rd_sel_i)
            REG_POL : irq_rd_data_o = dw'(pol_r);
            REG_IEN : irq_rd_data_o = dw'(ien_r);
            REG_IST : irq_rd_data_o = dw'(ist_r);
            default : irq_rd_data_o = '0;
        endcase
    end

    // irq only with an enabled status bit set
    a_irq_src : assert property (@(posedge clk) disable iff (!resetn)
        irq_o |-> (ist_r & ien_r) != '0)
        else $error("irq_o without enabled status");

    // irq rises only after a new edge or an enable write
    a_irq_rise : assert property (@(posedge clk) disable iff (!resetn)
        $rose(irq_o) |-> $past(edge_r != '0 || (wr_en_i && wr_sel_i == REG_IEN)))
        else $error("irq_o rose with no cause");

endmodule : gpio_edge_irq

// File: hdl/gpio_port_regs.sv
// output and direction registers plus the input synchronizer
// answers GPI, GPO and DIR reads, zero for every other select
`timescale 1ns/1ns
`include "gpio_macros.svh"

module gpio_port_regs
#(
    parameter int gpio_w = `GPIO_WIDTH
)(
    input   logic                           clk,
    input   logic                           resetn,
    // register port from the front end
    input   logic                           wr_en_i,
    input   gpio_pkg::gpio_reg_e            wr_sel_i,
    input   logic [`GPIO_AXI_DW-1:0]        wr_data_i,
    input   gpio_pkg::gpio_reg_e            rd_sel_i,
    // pads
    input   logic [gpio_w-1:0]              pad_in_i,   // async to clk
    output  logic [gpio_w-1:0]              pad_out_o,
    output  logic [gpio_w-1:0]              pad_dir_o,  // 1 = pin driven
    // to edge block and bus
    output  logic [gpio_w-1:0]              pin_sync_o,
    output  logic [`GPIO_AXI_DW-1:0]        port_rd_data_o
);
    import gpio_pkg::*;

    localparam int dw = `GPIO_AXI_DW;

    logic [gpio_w-1:0]  gpo_r;      // output value
    logic [gpio_w-1:0]  dir_r;      // direction
    logic [gpio_w-1:0]  sync_1;     // first flop, may go metastable
    logic [gpio_w-1:0]  sync_2;     // stable copy, GPI register

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            gpo_r <= '0;
            dir_r <= '0;
        end
        else if (wr_en_i)
        begin
            case (wr_sel_i)
                REG_GPO : gpo_r <= wr_data_i[gpio_w-1:0];
                REG_DIR : dir_r <= wr_data_i[gpio_w-1:0];
                default : ;     // GPI is read only, others live elsewhere
            endcase
        end
    end

    // two flops, pad change seen in GPI after 2 edges
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            sync_1 <= '0;
            sync_2 <= '0;
        end
        else
        begin
            sync_1 <= pad_in_i;
            sync_2 <= sync_1;
        end
    end

    assign pad_out_o  = gpo_r;
    assign pad_dir_o  = dir_r;
    assign pin_sync_o = sync_2;

    // read mux, upper bits zero extended
    always_comb
    begin
        case (rd_sel_i)
            REG_GPI : port_rd_data_o = dw'(sync_2);
            REG_GPO : port_rd_data_o = dw'(gpo_r);
            REG_DIR : port_rd_data_o = dw'(dir_r);
            default : port_rd_data_o = '0;
        endcase
    end

endmodule : gpio_port_regs

// File: hdl/gpio_reg_bus.sv
// AXI4-Lite slave for the GPIO block, one transaction in flight
// decodes addresses into register selects and returns merged read data
`timescale 1ns/1ns
`include "gpio_macros.svh"

module gpio_reg_bus
(
    input   logic                           clk,
    input   logic                           resetn,
    // write address / data
    input   logic [`GPIO_AXI_AW-1:0]        s_awaddr_i,
    input   logic                           s_awvalid_i,
    output  logic                           s_awready_o,
    input   logic [`GPIO_AXI_DW-1:0]        s_wdata_i,
    input   logic [`GPIO_AXI_DW/8-1:0]      s_wstrb_i,
    input   logic                           s_wvalid_i,
    output  logic                           s_wready_o,
    // write response
    output  logic [1:0]                     s_bresp_o,
    output  logic                           s_bvalid_o,
    input   logic                           s_bready_i,
    // read address / data
    input   logic [`GPIO_AXI_AW-1:0]        s_araddr_i,
    input   logic                           s_arvalid_i,
    output  logic                           s_arready_o,
    output  logic [`GPIO_AXI_DW-1:0]        s_rdata_o,
    output  logic [1:0]                     s_rresp_o,
    output  logic                           s_rvalid_o,
    input   logic                           s_rready_i,
    // register side
    output  logic                           wr_en_o,    // one cycle per good write
    output  gpio_pkg::gpio_reg_e            wr_sel_o,
    output  logic [`GPIO_AXI_DW-1:0]        wr_data_o,
    output  gpio_pkg::gpio_reg_e            rd_sel_o,
    input   logic [`GPIO_AXI_DW-1:0]        port_rd_data_i,
    input   logic [`GPIO_AXI_DW-1:0]        irq_rd_data_i
);
    import gpio_pkg::*;

    axil_state_e                state;
    gpio_reg_e                  aw_sel;     // decoded write target
    gpio_reg_e                  ar_sel;     // decoded read target
    logic                       write_req;  // aw and w both offered
    logic                       aw_hs;      // write accepted this edge
    logic                       ar_hs;      // read accepted this edge
    logic                       wr_ok;      // mapped and full strobe
    logic [1:0]                 bresp_r;
    logic [1:0]                 rresp_r;
    logic [`GPIO_AXI_DW-1:0]    rdata_r;

    // byte offset to register select, anything else is unmapped
    function automatic gpio_reg_e decode_addr(input logic [`GPIO_AXI_AW-1:0] addr);
        gpio_reg_e sel;
        case (addr)
            `GPIO_OFS_GPI : sel = REG_GPI;
            `GPIO_OFS_GPO : sel = REG_GPO;
            `GPIO_OFS_DIR : sel = REG_DIR;
            `GPIO_OFS_POL : sel = REG_POL;
            `GPIO_OFS_IEN : sel = REG_IEN;
            `GPIO_OFS_IST : sel = REG_IST;
            default       : sel = REG_NONE;
        endcase
        return sel;
    endfunction

    assign aw_sel    = decode_addr(s_awaddr_i);
    assign ar_sel    = decode_addr(s_araddr_i);
    assign write_req = s_awvalid_i && s_wvalid_i;

    // aw and w are taken together, a write beats a read in the same cycle
    assign s_awready_o = (state == ST_IDLE) && write_req;
    assign s_wready_o  = s_awready_o;
    assign s_arready_o = (state == ST_IDLE) && !write_req && s_arvalid_i;

    assign aw_hs = s_awready_o;     // readies only rise with valid high
    assign ar_hs = s_arready_o;

    // partial strobes and holes in the map are dropped
    assign wr_ok = (aw_sel != REG_NONE) && (&s_wstrb_i);

    assign wr_en_o   = aw_hs && wr_ok;
    assign wr_sel_o  = aw_sel;
    assign wr_data_o = s_wdata_i;
    assign rd_sel_o  = ar_sel;

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            state <= ST_IDLE;
        else
        begin
            case (state)
                ST_IDLE :
                begin
                    if (aw_hs)
                        state <= ST_BRESP;
                    else if (ar_hs)
                        state <= ST_RRESP;
                end
                ST_BRESP : if (s_bready_i) state <= ST_IDLE;  // wait out back-pressure
                ST_RRESP : if (s_rready_i) state <= ST_IDLE;
                default  : state <= ST_IDLE;
            endcase
        end
    end

    // response payload, only visible while the matching valid is high
    always_ff @(posedge clk)
    begin
        if (aw_hs)
            bresp_r <= wr_ok ? `GPIO_RESP_OKAY : `GPIO_RESP_SLVERR;
        if (ar_hs)
        begin
            rdata_r <= port_rd_data_i | irq_rd_data_i;   // unowned selects read zero
            rresp_r <= (ar_sel == REG_NONE) ? `GPIO_RESP_SLVERR : `GPIO_RESP_OKAY;
        end
    end

    assign s_bvalid_o = (state == ST_BRESP);
    assign s_bresp_o  = bresp_r;
    assign s_rvalid_o = (state == ST_RRESP);
    assign s_rresp_o  = rresp_r;
    assign s_rdata_o  = rdata_r;

    // only one response channel busy at a time
    a_resp_excl : assert property (@(posedge clk) disable iff (!resetn)
        !(s_bvalid_o && s_rvalid_o))
        else $error("bvalid and rvalid high together");

    // register strobe only with no response pending, answered OKAY next cycle
    a_wr_en_hs : assert property (@(posedge clk) disable iff (!resetn)
        wr_en_o |-> (!s_bvalid_o && !s_rvalid_o)
                    ##1 (s_bvalid_o && s_bresp_o == `GPIO_RESP_OKAY))
        else $error("wr_en without accepted write");

endmodule : gpio_reg_bus

// File: hdl/gpio_pkg.sv
// types shared by the GPIO front end and the two register blocks
// compile before any GPIO module
package gpio_pkg;

    // register select, decoded once in the bus front end
    typedef enum logic [2:0]
    {
        REG_GPI  = 3'd0,    // pad inputs
        REG_GPO  = 3'd1,    // output value
        REG_DIR  = 3'd2,    // direction
        REG_POL  = 3'd3,    // edge polarity
        REG_IEN  = 3'd4,    // irq enable
        REG_IST  = 3'd5,    // irq status
        REG_NONE = 3'd7     // unmapped address
    } gpio_reg_e;

    // AXI4-Lite front end states
    typedef enum logic [1:0]
    {
        ST_IDLE  = 2'd0,    // waiting for aw+w or ar
        ST_BRESP = 2'd1,    // write response pending
        ST_RRESP = 2'd2     // read data pending
    } axil_state_e;

endpackage : gpio_pkg

// File: hdl/gpio_macros.svh
// sizes, register offsets and AXI response codes for the GPIO peripheral
// include in every RTL file that needs them; the include dir is set in the file list
`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// pin count, any value from 1 to 32
`define GPIO_WIDTH          8

// AXI4-Lite port widths
`define GPIO_AXI_AW         8
`define GPIO_AXI_DW         32

// register byte offsets
`define GPIO_OFS_GPI        8'h00   // synchronized pad inputs, read only
`define GPIO_OFS_GPO        8'h04   // output value
`define GPIO_OFS_DIR        8'h08   // direction, 1 = output
`define GPIO_OFS_POL        8'h0C   // edge polarity, 1 = rising
`define GPIO_OFS_IEN        8'h10   // interrupt enable
`define GPIO_OFS_IST        8'h14   // sticky status, write one to clear

// bresp / rresp codes
`define GPIO_RESP_OKAY      2'b00
`define GPIO_RESP_SLVERR    2'b10

`endif
